// File: tb.f
+incdir+include
hdl/audio_pkg.sv
hdl/sample_fifo_if.sv
hdl/channel_mixer.sv
hdl/sample_fifo.sv
hdl/sigma_delta_dac.sv
hdl/audio_out_top.sv
sim/tb_audio_out.sv

// File: sim/tb_audio_out.sv
// Testbench for audio_out_top, drives LFSR sample pairs and checks outputs against a model
`timescale 1ns/100ps
`include "audio_defs.svh"

module tb_audio_out;

  localparam int SW          = `AUDIO_SAMPLE_W;
  localparam int CLK_PERIOD  = 40;                // ns
  localparam int N_TESTS     = 5;                 // Pass, swap, two blends, burst
  localparam int SAMPLES     = 12;                // Pairs per test, at most
  localparam int SLOW_PAIRS  = 10;
  localparam int WATCHDOG_CLKS = N_TESTS * SAMPLES * `AUDIO_DAC_DIV * 4 + 1000;

  logic          i_clk_28 = 1'b0;
  logic          i_rst;
  logic          i_exchan;
  logic          i_mix;
  logic          i_sample_stb;
  logic [SW-1:0] i_ldata;
  logic [SW-1:0] i_rdata;
  logic          o_dac_stb;
  logic [SW-1:0] o_dac_left;
  logic [SW-1:0] o_dac_right;
  logic          o_audio_left;
  logic          o_audio_right;
  logic          o_overflow;

  logic [31:0]     lfsr_state;       // Stimulus source
  logic [2*SW-1:0] exp_q [$];        // Expected pairs, left in upper half
  bit              keep_q [$];       // Pair may not be dropped
  logic [SW:0]     acc_l;            // Modulator model, MSB is carry
  logic [SW:0]     acc_r;
  logic [SW-1:0]   hold_l;           // Model hold registers
  logic [SW-1:0]   hold_r;
  bit              prev_rst;         // Reset seen at last rising edge
  bit              idle_check;
  bit              burst_phase;
  int              checks;
  int              mismatches;
  int              other_errs;
  int              ovf_count;
  int              dropped;

  audio_out_top audio_out_top_inst (
    .i_clk_28     (i_clk_28     ),
    .i_rst        (i_rst        ),
    .i_exchan     (i_exchan     ),
    .i_mix        (i_mix        ),
    .i_sample_stb (i_sample_stb ),
    .i_ldata      (i_ldata      ),
    .i_rdata      (i_rdata      ),
    .o_dac_stb    (o_dac_stb    ),
    .o_dac_left   (o_dac_left   ),
    .o_dac_right  (o_dac_right  ),
    .o_audio_left (o_audio_left ),
    .o_audio_right(o_audio_right),
    .o_overflow   (o_overflow   )
  );

  always #(CLK_PERIOD / 2) i_clk_28 = ~i_clk_28;

  ////////////////////
  // Reference rules
  ////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois, x^32+x^22+x^2+x+1
  endfunction

  // Own side three quarters, other side one quarter, floor shifts
  function automatic logic [SW-1:0] blend_ref(input logic [SW-1:0] a, input logic [SW-1:0] b);
    int ai;
    int bi;
    ai = $signed(a);
    bi = $signed(b);
    return SW'(ai - (ai >>> 2) + (bi >>> 2));
  endfunction

  function automatic logic [SW-1:0] offset_ref(input logic [SW-1:0] s);
    return s + (SW'(1) << (SW - 1));  // Half scale added, wraps
  endfunction

  function automatic logic [2*SW-1:0] expected_pair(input logic [SW-1:0] l,
                                                    input logic [SW-1:0] r,
                                                    input logic ex, input logic mx);
    logic [SW-1:0] a;
    logic [SW-1:0] b;
    a = ex ? r : l;
    b = ex ? l : r;
    if (mx) begin
      return {blend_ref(a, b), blend_ref(b, a)};
    end
    return {a, b};
  endfunction

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic random_sample(output logic [SW-1:0] v);
    v = '0;
    for (int i = 0; i < SW; i++) begin
      v = {v[SW-2:0], lfsr_state[0]};   // One LFSR step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic set_switches(input logic ex, input logic mx);
    @(posedge i_clk_28);
    #2;
    i_exchan = ex;
    i_mix    = mx;
    repeat (`AUDIO_SYNC_STAGES + 4) @(posedge i_clk_28);  // Sync delay plus idle clocks
  endtask

  task automatic drive_pair(input bit keep);
    logic [SW-1:0] l;
    logic [SW-1:0] r;
    random_sample(l);
    random_sample(r);
    @(posedge i_clk_28);
    #2;
    i_sample_stb = 1'b1;
    i_ldata      = l;
    i_rdata      = r;
    exp_q.push_back(expected_pair(l, r, i_exchan, i_mix));
    keep_q.push_back(keep);
  endtask

  task automatic release_strobe();
    @(posedge i_clk_28);
    #2;
    i_sample_stb = 1'b0;
  endtask

  task automatic wait_delivered();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 3 * `AUDIO_DAC_DIV) begin
      @(posedge i_clk_28);
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("no o_dac_stb for a strobed pair within %0d clocks at %0t", waited, $time);
      exp_q.delete();
      keep_q.delete();
    end
  endtask

  task automatic send_slow(input int n);
    for (int i = 0; i < n; i++) begin
      drive_pair(1'b1);
      release_strobe();
      wait_delivered();                  // Slower than the DAC rate
      repeat (2) @(posedge i_clk_28);
    end
  endtask

  // Done once no strobe shows for two DAC periods
  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 2 * `AUDIO_DAC_DIV) begin
      @(negedge i_clk_28);
      quiet = o_dac_stb ? 0 : quiet + 1;
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, mismatches %0d, other errors %0d, overflows %0d, dropped %0d",
             checks, mismatches, other_errs, ovf_count, dropped);
  endtask

  ////////////////////
  // Output checking
  ////////////////////

  task automatic match_output();
    logic [2*SW-1:0] got;
    logic [2*SW-1:0] exp;
    got = {o_dac_left, o_dac_right};
    while (exp_q.size() > 0 && !keep_q[0] && exp_q[0] != got) begin
      void'(exp_q.pop_front());          // Lost to overflow
      void'(keep_q.pop_front());
      dropped++;
    end
    if (exp_q.size() == 0) begin
      other_errs++;
      $display("o_dac_stb at %0t with no pair outstanding", $time);
    end else begin
      exp = exp_q.pop_front();
      void'(keep_q.pop_front());
      checks += 2;
      assert (o_dac_left === exp[2*SW-1:SW]) else begin
        mismatches++;
        $display("mismatch at %0t: o_dac_left %h, expected %h", $time, o_dac_left,
                 exp[2*SW-1:SW]);
      end
      assert (o_dac_right === exp[SW-1:0]) else begin
        mismatches++;
        $display("mismatch at %0t: o_dac_right %h, expected %h", $time, o_dac_right,
                 exp[SW-1:0]);
      end
    end
  endtask

  // Mid-cycle sampling, one rising edge between two passes
  always @(negedge i_clk_28) begin
    if (prev_rst) begin
      acc_l  = '0;
      acc_r  = '0;
      hold_l = '0;
      hold_r = '0;
    end else begin
      acc_l = {1'b0, acc_l[SW-1:0]} + {1'b0, offset_ref(hold_l)};  // Add with old hold
      acc_r = {1'b0, acc_r[SW-1:0]} + {1'b0, offset_ref(hold_r)};
      if (o_dac_stb) begin
        hold_l = o_dac_left;
        hold_r = o_dac_right;
        match_output();
      end
      if (o_overflow) begin
        ovf_count++;
        assert (burst_phase) else begin
          other_errs++;
          $display("o_overflow pulsed outside the burst test at %0t", $time);
        end
      end
      if (idle_check) begin
        checks++;
        assert ({o_dac_stb, o_overflow, o_dac_left, o_dac_right} === '0) else begin
          mismatches++;
          $display("mismatch at %0t: idle o_dac_stb %b o_overflow %b o_dac_left %h %s %h, %s",
                   $time, o_dac_stb, o_overflow, o_dac_left, "o_dac_right", o_dac_right,
                   "expected all zero");
        end
      end
    end
    checks += 2;
    assert (o_audio_left === acc_l[SW]) else begin
      mismatches++;
      $display("mismatch at %0t: o_audio_left %b, expected %b", $time, o_audio_left, acc_l[SW]);
    end
    assert (o_audio_right === acc_r[SW]) else begin
      mismatches++;
      $display("mismatch at %0t: o_audio_right %b, expected %b", $time, o_audio_right,
               acc_r[SW]);
    end
    prev_rst = i_rst;
  end

  a_stb_single : assert property (
    @(posedge i_clk_28) disable iff (i_rst)
    o_dac_stb |=> !o_dac_stb
  ) else begin
    other_errs++;
    $display("o_dac_stb stayed high for two cycles at %0t", $time);
  end

  // Parallel outputs change only together with the strobe
  a_hold_stable : assert property (
    @(posedge i_clk_28) disable iff (i_rst)
    ({o_dac_left, o_dac_right} != $past({o_dac_left, o_dac_right})) |-> o_dac_stb
  ) else begin
    other_errs++;
    $display("o_dac_left or o_dac_right changed without o_dac_stb at %0t", $time);
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    i_rst        = 1'b1;
    i_exchan     = 1'b0;
    i_mix        = 1'b0;
    i_sample_stb = 1'b0;
    i_ldata      = '0;
    i_rdata      = '0;
    lfsr_state   = 32'h5176_a77b;
    prev_rst     = 1'b1;
    repeat (5) @(posedge i_clk_28);
    #2;
    i_rst      = 1'b0;
    idle_check = 1'b1;                    // No samples yet, outputs quiet
    repeat (3 * `AUDIO_DAC_DIV) @(posedge i_clk_28);
    idle_check = 1'b0;
    set_switches(1'b0, 1'b0);             // Pass-through
    send_slow(SLOW_PAIRS);
    set_switches(1'b1, 1'b0);             // Swap
    send_slow(SLOW_PAIRS);
    set_switches(1'b0, 1'b1);             // Blend
    send_slow(SLOW_PAIRS);
    set_switches(1'b1, 1'b1);             // Swap and blend
    send_slow(SLOW_PAIRS);
    set_switches(1'b0, 1'b0);
    burst_phase = 1'b1;                   // Strobe every clock
    for (int i = 0; i < SAMPLES; i++) begin
      drive_pair(i < `AUDIO_FIFO_DEPTH);  // First FIFO-full never lost
    end
    release_strobe();
    wait_quiet();
    burst_phase = 1'b0;
    while (exp_q.size() > 0) begin
      if (keep_q[0]) begin
        other_errs++;
        $display("a pair that had room in the FIFO never reached the DAC outputs");
      end else begin
        dropped++;
      end
      void'(exp_q.pop_front());
      void'(keep_q.pop_front());
    end
    if (ovf_count == 0) begin
      other_errs++;
      $display("the burst of back-to-back strobes gave no overflow pulse");
    end
    if (ovf_count != dropped) begin
      other_errs++;
      $display("overflow pulses (%0d) differ from pairs missing at the output (%0d)",
               ovf_count, dropped);
    end
    print_counts();
    if (mismatches == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("watchdog expired, the test sequence did not finish in time");
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: hdl/audio_out_top.sv
// Audio output path top, mixer into sample FIFO into sigma-delta DAC on the 28 MHz clock
`timescale 1ns/100ps
`include "audio_defs.svh"

module audio_out_top (
  input  logic                       i_clk_28,       // 28 MHz clock
  input  logic                       i_rst,          // Sync reset, active high
  input  logic                       i_exchan,       // Swap switch, async
  input  logic                       i_mix,          // Mix switch, async
  input  logic                       i_sample_stb,   // Chipset sample strobe
  input  logic [`AUDIO_SAMPLE_W-1:0] i_ldata,        // Chipset left sample
  input  logic [`AUDIO_SAMPLE_W-1:0] i_rdata,        // Chipset right sample
  output logic                       o_dac_stb,      // Parallel pair strobe
  output logic [`AUDIO_SAMPLE_W-1:0] o_dac_left,     // Parallel left sample
  output logic [`AUDIO_SAMPLE_W-1:0] o_dac_right,    // Parallel right sample
  output logic                       o_audio_left,   // Sigma-delta left
  output logic                       o_audio_right,  // Sigma-delta right
  output logic                       o_overflow      // Dropped sample pulse
);

  ////////////////////
  // Internal signals
  ////////////////////

  logic                       mix_push;   // Mixer write strobe
  logic [`AUDIO_SAMPLE_W-1:0] mix_left;   // Mixed pair into FIFO
  logic [`AUDIO_SAMPLE_W-1:0] mix_right;

  sample_fifo_if rd_if ();                // FIFO to DAC read side

  ////////////////////
  // Modules
  ////////////////////

  channel_mixer channel_mixer_inst (
    .i_clk_28     (i_clk_28     ),
    .i_rst        (i_rst        ),
    .i_exchan     (i_exchan     ),  // Swap left/right
    .i_mix        (i_mix        ),  // Centered blend
    .i_sample_stb (i_sample_stb ),
    .i_ldata      (i_ldata      ),
    .i_rdata      (i_rdata      ),
    .o_push       (mix_push     ),
    .o_left       (mix_left     ),
    .o_right      (mix_right    )
  );

  sample_fifo sample_fifo_inst (
    .i_clk_28     (i_clk_28     ),
    .i_rst        (i_rst        ),
    .i_push       (mix_push     ),
    .i_left       (mix_left     ),
    .i_right      (mix_right    ),
    .o_overflow   (o_overflow   ),  // Full, pair lost
    .rd           (rd_if.fifo   )
  );

  sigma_delta_dac sigma_delta_dac_inst (
    .i_clk_28     (i_clk_28     ),
    .i_rst        (i_rst        ),
    .rd           (rd_if.dac    ),
    .o_dac_stb    (o_dac_stb    ),  // Toward codec shifter
    .o_dac_left   (o_dac_left   ),
    .o_dac_right  (o_dac_right  ),
    .o_audio_left (o_audio_left ),
    .o_audio_right(o_audio_right)
  );

endmodule

// File: hdl/sigma_delta_dac.sv
// Sigma-delta DAC, pops one pair per rate tick, strobes it out in parallel, and modulates
`timescale 1ns/100ps
`include "audio_defs.svh"

module sigma_delta_dac (
  input  logic                       i_clk_28,       // 28 MHz clock
  input  logic                       i_rst,          // Sync reset, active high
  sample_fifo_if.dac                 rd,             // Read side of sample FIFO
  output logic                       o_dac_stb,      // New held pair, toward codec
  output logic [`AUDIO_SAMPLE_W-1:0] o_dac_left,     // Held left sample
  output logic [`AUDIO_SAMPLE_W-1:0] o_dac_right,    // Held right sample
  output logic                       o_audio_left,   // Left bitstream
  output logic                       o_audio_right   // Right bitstream
);

  localparam int DIV_W = $clog2(`AUDIO_DAC_DIV);  // Rate counter bits

  ////////////////////
  // Internal signals
  ////////////////////

  logic [DIV_W-1:0]                 div_cnt;    // Free-running rate counter
  logic                             tick;       // One cycle per DAC period
  logic [1:0][`AUDIO_SAMPLE_W-1:0]  fifo_word;  // Oldest pair, index 0 is left

  ////////////////////
  // Rate tick
  ////////////////////

  always_ff @(posedge i_clk_28) begin
    if (i_rst) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;                   // Period restart
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
    end
  end

  assign tick = (div_cnt == DIV_W'(`AUDIO_DAC_DIV - 1));

  ////////////////////
  // FIFO read and strobe
  ////////////////////

  assign rd.rd_pop = tick & ~rd.rd_empty;    // Empty tick keeps old hold
  assign fifo_word = {rd.rd_right, rd.rd_left};

  always_ff @(posedge i_clk_28) begin
    if (i_rst) begin
      o_dac_stb <= 1'b0;
    end else begin
      o_dac_stb <= rd.rd_pop;                // Marks fresh hold values
    end
  end

  ////////////////////
  // Hold and modulators
  ////////////////////

  // Same first-order loop per channel, index 0 left, 1 right
  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    logic [`AUDIO_SAMPLE_W-1:0] hold;        // Sample under conversion
    logic [`AUDIO_SAMPLE_W:0]   acc;         // MSB is registered carry

    always_ff @(posedge i_clk_28) begin
      if (i_rst) begin
        hold <= '0;                          // Midscale after to_offset
        acc  <= '0;
      end else begin
        if (rd.rd_pop) begin
          hold <= fifo_word[ch];
        end
        // Carry out drops back to zero on the next add
        acc <= {1'b0, acc[`AUDIO_SAMPLE_W-1:0]} + {1'b0, audio_pkg::to_offset($signed(hold))};
      end
    end
  end

  assign o_dac_left    = g_chan[0].hold;
  assign o_dac_right   = g_chan[1].hold;
  assign o_audio_left  = g_chan[0].acc[`AUDIO_SAMPLE_W];   // Density follows level
  assign o_audio_right = g_chan[1].acc[`AUDIO_SAMPLE_W];

  // Strobe only ever follows a rate tick
  a_stb_after_tick : assert property (
    @(posedge i_clk_28) disable iff (i_rst)
    o_dac_stb |-> $past(tick)
  ) else $error("sigma_delta_dac: strobe without preceding tick");

endmodule

// File: hdl/sample_fifo.sv
// Stereo sample FIFO between chipset rate and DAC rate, drops and flags pushes when full
`timescale 1ns/100ps
`include "audio_defs.svh"

module sample_fifo (
  input  logic                       i_clk_28,    // 28 MHz clock
  input  logic                       i_rst,       // Sync reset, active high
  input  logic                       i_push,      // Write strobe from mixer
  input  logic [`AUDIO_SAMPLE_W-1:0] i_left,      // Left sample to store
  input  logic [`AUDIO_SAMPLE_W-1:0] i_right,     // Right sample to store
  output logic                       o_overflow,  // One cycle, push was dropped
  sample_fifo_if.fifo                rd           // Read side toward DAC
);

  localparam int PTR_W = $clog2(`AUDIO_FIFO_DEPTH);      // Pointer bits
  localparam int CNT_W = $clog2(`AUDIO_FIFO_DEPTH + 1);  // Count up to depth

  ////////////////////
  // Internal signals
  ////////////////////

  logic [`AUDIO_SAMPLE_W-1:0] left_mem  [`AUDIO_FIFO_DEPTH];  // Left channel store
  logic [`AUDIO_SAMPLE_W-1:0] right_mem [`AUDIO_FIFO_DEPTH];  // Right channel store
  logic [PTR_W-1:0]           wr_ptr;                         // Next free slot
  logic [PTR_W-1:0]           rd_ptr;                         // Oldest entry
  logic [CNT_W-1:0]           count;                          // Entries held
  logic                       full;
  logic                       wr_en;                          // Accepted push
  logic                       rd_en;                          // Accepted pop

  assign full  = (count == CNT_W'(`AUDIO_FIFO_DEPTH));
  assign wr_en = i_push & ~full;         // Full means drop, no back-pressure
  assign rd_en = rd.rd_pop & ~rd.rd_empty;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge i_clk_28) begin
    if (wr_en) begin
      left_mem[wr_ptr]  <= i_left;
      right_mem[wr_ptr] <= i_right;
    end
  end

  assign rd.rd_left  = left_mem[rd_ptr];   // Oldest entry always visible
  assign rd.rd_right = right_mem[rd_ptr];
  assign rd.rd_empty = (count == '0);

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge i_clk_28) begin
    if (i_rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end else begin
      o_overflow <= i_push & full;         // Flag each lost pair
      if (wr_en) begin
        wr_ptr <= wr_ptr + PTR_W'(1);      // Wraps, depth is power of two
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;           // Idle or simultaneous
      endcase
    end
  end

  // DAC must respect the empty flag
  a_no_pop_empty : assert property (
    @(posedge i_clk_28) disable iff (i_rst)
    rd.rd_pop |-> !rd.rd_empty
  ) else $error("sample_fifo: pop while empty");

  // Occupancy bookkeeping stays within the buffer
  a_count_bound : assert property (
    @(posedge i_clk_28) disable iff (i_rst)
    count <= CNT_W'(`AUDIO_FIFO_DEPTH)
  ) else $error("sample_fifo: count above depth");

endmodule

// File: hdl/channel_mixer.sv
// Channel mixer, synchronizes the swap and mix switches and registers each strobed pair
`timescale 1ns/100ps
`include "audio_defs.svh"

module channel_mixer (
  input  logic                       i_clk_28,      // 28 MHz clock
  input  logic                       i_rst,         // Sync reset, active high
  input  logic                       i_exchan,      // Swap left/right, async level
  input  logic                       i_mix,         // Centered blend, async level
  input  logic                       i_sample_stb,  // New chipset sample pair
  input  logic [`AUDIO_SAMPLE_W-1:0] i_ldata,       // Left chipset sample
  input  logic [`AUDIO_SAMPLE_W-1:0] i_rdata,       // Right chipset sample
  output logic                       o_push,        // One cycle write strobe
  output logic [`AUDIO_SAMPLE_W-1:0] o_left,        // Mixed left sample
  output logic [`AUDIO_SAMPLE_W-1:0] o_right        // Mixed right sample
);

  ////////////////////
  // Internal signals
  ////////////////////

  logic [`AUDIO_SYNC_STAGES-1:0] exchan_sync;  // Swap switch chain
  logic [`AUDIO_SYNC_STAGES-1:0] mix_sync;     // Mix switch chain
  logic                          exchan;       // Synced swap setting
  logic                          mix;          // Synced mix setting
  logic [`AUDIO_SAMPLE_W-1:0]    swap_l;       // After swap
  logic [`AUDIO_SAMPLE_W-1:0]    swap_r;
  logic [`AUDIO_SAMPLE_W-1:0]    mix_l;        // After optional blend
  logic [`AUDIO_SAMPLE_W-1:0]    mix_r;

  ////////////////////
  // Switch synchronizers
  ////////////////////

  always_ff @(posedge i_clk_28) begin
    if (i_rst) begin
      exchan_sync <= '0;                                                   // Both off
      mix_sync    <= '0;
    end else begin
      exchan_sync <= {exchan_sync[`AUDIO_SYNC_STAGES-2:0], i_exchan};      // Shift in
      mix_sync    <= {mix_sync[`AUDIO_SYNC_STAGES-2:0], i_mix};
    end
  end

  assign exchan = exchan_sync[`AUDIO_SYNC_STAGES-1];  // Last stage only
  assign mix    = mix_sync[`AUDIO_SYNC_STAGES-1];

  ////////////////////
  // Swap and blend
  ////////////////////

  assign swap_l = exchan ? i_rdata : i_ldata;  // Exchange channels
  assign swap_r = exchan ? i_ldata : i_rdata;

  // Each side keeps 3/4 of itself and takes 1/4 of the other
  assign mix_l = mix ? audio_pkg::blend($signed(swap_l), $signed(swap_r)) : swap_l;
  assign mix_r = mix ? audio_pkg::blend($signed(swap_r), $signed(swap_l)) : swap_r;

  ////////////////////
  // Output registers
  ////////////////////

  always_ff @(posedge i_clk_28) begin
    if (i_rst) begin
      o_push <= 1'b0;
    end else begin
      o_push <= i_sample_stb;  // Push one cycle after capture edge
    end
  end

  always_ff @(posedge i_clk_28) begin
    if (i_sample_stb) begin
      o_left  <= mix_l;        // Payload, only loaded on strobe
      o_right <= mix_r;
    end
  end

  // Back-to-back pushes need back-to-back chipset strobes
  a_push_spacing : assert property (
    @(posedge i_clk_28) disable iff (i_rst)
    (o_push && $past(o_push)) |-> ($past(i_sample_stb, 1) && $past(i_sample_stb, 2))
  ) else $error("channel_mixer: consecutive pushes without consecutive strobes");

endmodule

// File: hdl/sample_fifo_if.sv
// Read side bundle of the sample FIFO, FIFO drives data and status, DAC drives pop
`timescale 1ns/100ps
`include "audio_defs.svh"

interface sample_fifo_if;

  logic                       rd_pop;    // Remove oldest entry this edge
  logic [`AUDIO_SAMPLE_W-1:0] rd_left;   // Oldest entry, left channel
  logic [`AUDIO_SAMPLE_W-1:0] rd_right;  // Oldest entry, right channel
  logic                       rd_empty;  // No entry present

  // Buffer side
  modport fifo (
    input  rd_pop,
    output rd_left,
    output rd_right,
    output rd_empty
  );

  // Consumer side, pops only on its own rate tick
  modport dac (
    output rd_pop,
    input  rd_left,
    input  rd_right,
    input  rd_empty
  );

endinterface

// File: hdl/audio_pkg.sv
// Sample arithmetic for the audio path, called through audio_pkg:: scoped names
`include "audio_defs.svh"

package audio_pkg;

  ////////////////////
  // Channel blend
  ////////////////////

  // Three quarters of own channel plus a quarter of the other one.
  // Worst case stays inside the signed range, so no saturation needed.
  function automatic logic signed [`AUDIO_SAMPLE_W-1:0] blend(
    input logic signed [`AUDIO_SAMPLE_W-1:0] a,  // Own channel
    input logic signed [`AUDIO_SAMPLE_W-1:0] b   // Opposite channel
  );
    logic signed [`AUDIO_SAMPLE_W-1:0] a_q;      // a / 4, rounded down
    logic signed [`AUDIO_SAMPLE_W-1:0] b_q;      // b / 4, rounded down
    a_q = a >>> 2;
    b_q = b >>> 2;
    return a - a_q + b_q;
  endfunction

  ////////////////////
  // DAC number format
  ////////////////////

  // Two's complement to offset binary, midscale sits at 0x4000
  function automatic logic [`AUDIO_SAMPLE_W-1:0] to_offset(
    input logic signed [`AUDIO_SAMPLE_W-1:0] s   // Signed sample
  );
    return {~s[`AUDIO_SAMPLE_W-1], s[`AUDIO_SAMPLE_W-2:0]};  // Flip sign bit only
  endfunction

endpackage

// File: include/audio_defs.svh
// Sizing macros for the audio output path, included by the RTL and the testbench
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

////////////////////
// Sample format
////////////////////

`define AUDIO_SAMPLE_W     15   // Signed chipset sample, per channel

////////////////////
// Switch inputs
////////////////////

`define AUDIO_SYNC_STAGES  2    // Flops per switch synchronizer

////////////////////
// Buffering and rate
////////////////////

`define AUDIO_FIFO_DEPTH   4    // Stereo entries, power of two
`define AUDIO_DAC_DIV      16   // Clocks between DAC sample ticks

`endif
